// ==== design/ring_geometry_pkg.sv ====
// Ring geometry: page and ring sizes, sync-area layout and address types

package ring_geometry_pkg;

   // ------------------------------------------------------------------------
   // Page and ring sizes
   // ------------------------------------------------------------------------

   // 66-bit blocks stored per 4 KB page
   localparam int blocks_per_page = 496;

   // Pages in the ring
   localparam int page_count = 32;

   // 128-bit words per page, 4096 / 16
   localparam int words_per_page = 256;

   // First 128 bytes of a page hold the sync headers
   localparam int sync_words_per_page = 8;

   // ------------------------------------------------------------------------
   // Sync-area layout
   // ------------------------------------------------------------------------

   // 2-bit headers packed per 128-bit word
   localparam int hdrs_per_word = 64;

   // Last sync word holding headers, the partly filled one
   localparam int last_sync_word = blocks_per_page / hdrs_per_word;

   // Valid headers in that last word, 48 of 64
   localparam int sync_tail_hdrs = blocks_per_page % hdrs_per_word;

   // ------------------------------------------------------------------------
   // Address types
   // ------------------------------------------------------------------------

   typedef logic [4:0]  page_t;      // Page number in the ring
   typedef logic [8:0]  slot_t;      // Block index in a page, 0 to 495
   typedef logic [12:0] dma_addr_t;  // Page in 12:8, word in 7:0
   typedef logic [5:0]  page_cnt_t;  // Completed pages, wraps at 64

endpackage

// ==== design/block_format_pkg.sv ====
// Block format: header, payload and block widths and types, DMA word type

package block_format_pkg;

   // Sync header from blocksync
   localparam int hdr_width = 2;

   // Scrambled payload
   localparam int payload_width = 64;

   // Full block, header in the low bits
   localparam int block_width = hdr_width + payload_width;

   // Read width of the DMA engine
   localparam int dma_word_width = 128;

   typedef logic [hdr_width-1:0]      sync_hdr_t;
   typedef logic [payload_width-1:0]  payload_t;

   // Bits 65:2 payload, bits 1:0 header
   typedef logic [block_width-1:0]    block_t;

   typedef logic [dma_word_width-1:0] dma_word_t;

endpackage

// ==== design/block_write_counter.sv ====
// Block write counter: input register plus page and slot placement of each block

`timescale 1ns/1ps

module block_write_counter (
   input  logic                        wr_clk,
   input  logic                        reset,
   input  logic                        wrena,
   input  logic                        wrreq,
   input  block_format_pkg::block_t    data_in,
   output block_format_pkg::block_t    wr_block,
   output ring_geometry_pkg::page_t    wr_page,
   output ring_geometry_pkg::slot_t    wr_slot,
   output logic                        wr_strobe,
   output logic                        page_done
);

   // Placement of the next accepted block
   ring_geometry_pkg::page_t cur_page;
   ring_geometry_pkg::slot_t cur_slot;

   logic accept;
   logic last_slot;

   // A block counts only when both the level and the strobe are up
   assign accept    = wrena & wrreq;
   assign last_slot = (cur_slot == ring_geometry_pkg::slot_t'(
                                      ring_geometry_pkg::blocks_per_page - 1));

   // Block register, header and payload
   always_ff @(posedge wr_clk) begin
      if (accept) begin
         wr_block <= data_in;
      end
   end

   // Placement counters and write strobes
   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset) begin
         cur_page  <= '0;
         cur_slot  <= '0;
         wr_page   <= '0;
         wr_slot   <= '0;
         wr_strobe <= 1'b0;
         page_done <= 1'b0;
      end else begin
         wr_strobe <= accept;
         // Same cycle as the write of slot 495
         page_done <= accept & last_slot;
         if (accept) begin
            wr_page <= cur_page;
            wr_slot <= cur_slot;
            if (last_slot) begin
               cur_slot <= '0;
               // Ring wraps after the last page, old pages get overwritten
               if (cur_page == ring_geometry_pkg::page_t'(ring_geometry_pkg::page_count - 1))
                  cur_page <= '0;
               else
                  cur_page <= cur_page + 1'b1;
            end else begin
               cur_slot <= cur_slot + 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/sync_header_ring.sv ====
// Sync-header ring: 2-bit writes on wr_clk, masked 128-bit registered reads on rd_clk

`timescale 1ns/1ps

module sync_header_ring (
   input  logic                          wr_clk,
   input  logic                          rd_clk,
   input  ring_geometry_pkg::page_t      wr_page,
   input  ring_geometry_pkg::slot_t      wr_slot,
   input  block_format_pkg::sync_hdr_t   wr_hdr,
   input  logic                          wr_strobe,
   input  ring_geometry_pkg::page_t      rd_page,
   input  logic [2:0]                    rd_word,
   output block_format_pkg::dma_word_t   rd_data
);

   // 8 words per page, 32 pages
   block_format_pkg::dma_word_t mem [ring_geometry_pkg::page_count *
                                     ring_geometry_pkg::sync_words_per_page];

   logic [7:0] wr_addr;
   logic [7:0] rd_addr;
   logic [6:0] wr_bit;

   // Low bits kept in the last sync word, headers 448 to 495
   block_format_pkg::dma_word_t tail_mask;

   // ------------------------------------------------------------------------
   // Write side
   // ------------------------------------------------------------------------

   // Slot bits 8:6 pick the word, bits 5:0 the header position in it
   assign wr_addr = {wr_page, wr_slot[8:6]};
   assign wr_bit  = {wr_slot[5:0], 1'b0};

   always_ff @(posedge wr_clk) begin
      if (wr_strobe) begin
         mem[wr_addr][wr_bit +: block_format_pkg::hdr_width] <= wr_hdr;
      end
   end

   // ------------------------------------------------------------------------
   // Read side
   // ------------------------------------------------------------------------

   assign rd_addr   = {rd_page, rd_word};
   assign tail_mask = {block_format_pkg::dma_word_width{1'b1}} >>
                      (block_format_pkg::dma_word_width -
                       block_format_pkg::hdr_width * ring_geometry_pkg::sync_tail_hdrs);

   // Positions 496 to 511 are never written
   // Bytes 124 to 127 forced to zero here
   always_ff @(posedge rd_clk) begin
      if (rd_word == 3'(ring_geometry_pkg::last_sync_word))
         rd_data <= mem[rd_addr] & tail_mask;
      else
         rd_data <= mem[rd_addr];
   end

endmodule

// ==== design/data_block_ring.sv ====
// Payload ring: 64-bit half-word writes on wr_clk, 128-bit registered reads on rd_clk

`timescale 1ns/1ps

module data_block_ring (
   input  logic                          wr_clk,
   input  logic                          rd_clk,
   input  ring_geometry_pkg::page_t      wr_page,
   input  ring_geometry_pkg::slot_t      wr_slot,
   input  block_format_pkg::payload_t    wr_payload,
   input  logic                          wr_strobe,
   input  ring_geometry_pkg::dma_addr_t  rd_address,
   output block_format_pkg::dma_word_t   rd_data
);

   // Two 64-bit banks, one per half of the DMA word
   // Same address map as the DMA, words 0 to 7 of each page stay unused
   block_format_pkg::payload_t mem_lo [ring_geometry_pkg::page_count *
                                       ring_geometry_pkg::words_per_page];
   block_format_pkg::payload_t mem_hi [ring_geometry_pkg::page_count *
                                       ring_geometry_pkg::words_per_page];

   logic [7:0]                   wr_word;
   ring_geometry_pkg::dma_addr_t wr_addr;

   // Payload pair k/2 lands after the sync area, words 8 to 255
   assign wr_word = 8'(ring_geometry_pkg::sync_words_per_page) + wr_slot[8:1];
   assign wr_addr = {wr_page, wr_word};

   // Even slot to the low half, odd slot to the high half
   always_ff @(posedge wr_clk) begin
      if (wr_strobe) begin
         if (wr_slot[0])
            mem_hi[wr_addr] <= wr_payload;
         else
            mem_lo[wr_addr] <= wr_payload;
      end
   end

   // Registered read, one rd_clk of latency
   always_ff @(posedge rd_clk) begin
      rd_data <= {mem_hi[rd_address], mem_lo[rd_address]};
   end

endmodule

// ==== design/page_read_mux.sv ====
// Page read mux: DMA address decode, sync-ring address and delayed output select

`timescale 1ns/1ps

module page_read_mux (
   input  logic                          rd_clk,
   input  logic                          reset,
   input  ring_geometry_pkg::dma_addr_t  rd_address,
   output ring_geometry_pkg::page_t      sync_page,
   output logic [2:0]                    sync_word,
   input  block_format_pkg::dma_word_t   sync_data,
   input  block_format_pkg::dma_word_t   payload_data,
   output block_format_pkg::dma_word_t   data_out
);

   // High when the registered word came from the payload ring
   logic data_sel;

   // DMA 0x000-0x007 to sync 0x00-0x07, 0x100-0x107 to 0x08-0x0f, ...
   assign sync_page = rd_address[12:8];
   assign sync_word = rd_address[2:0];

   // Select delayed by one rd_clk, same as both RAM reads
   // Word 8 and above is payload, i.e. any of bits 7:3 set
   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset)
         data_sel <= 1'b0;
      else
         data_sel <= (rd_address[7:0] >= 8'(ring_geometry_pkg::sync_words_per_page));
   end

   assign data_out = data_sel ? payload_data : sync_data;

endmodule

// ==== design/page_count_crosser.sv ====
// Page count crosser: completed-page counter on wr_clk, Gray transfer to rd_clk

`timescale 1ns/1ps

module page_count_crosser (
   input  logic                          wr_clk,
   input  logic                          rd_clk,
   input  logic                          reset,
   input  logic                          page_done,
   output ring_geometry_pkg::page_cnt_t  wr_page_count
);

   ring_geometry_pkg::page_cnt_t wr_count;
   ring_geometry_pkg::page_cnt_t wr_count_next;
   ring_geometry_pkg::page_cnt_t wr_gray;
   ring_geometry_pkg::page_cnt_t rd_gray_meta;
   ring_geometry_pkg::page_cnt_t rd_gray;

   // Gray to binary, running XOR from the top bit down
   function automatic ring_geometry_pkg::page_cnt_t gray_to_bin(
      input ring_geometry_pkg::page_cnt_t gray
   );
      ring_geometry_pkg::page_cnt_t bin;
      bin[$high(bin)] = gray[$high(gray)];
      for (int i = $high(bin) - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

   // ------------------------------------------------------------------------
   // Write clock side
   // ------------------------------------------------------------------------

   assign wr_count_next = wr_count + ring_geometry_pkg::page_cnt_t'(page_done);

   // Gray copy follows the count on the same edge
   // Only one bit moves per page, safe to sample from rd_clk
   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset) begin
         wr_count <= '0;
         wr_gray  <= '0;
      end else begin
         wr_count <= wr_count_next;
         wr_gray  <= wr_count_next ^ (wr_count_next >> 1);
      end
   end

   // ------------------------------------------------------------------------
   // Read clock side
   // ------------------------------------------------------------------------

   // Two-flop synchronizer
   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset) begin
         rd_gray_meta <= '0;
         rd_gray      <= '0;
      end else begin
         rd_gray_meta <= wr_gray;
         rd_gray      <= rd_gray_meta;
      end
   end

   assign wr_page_count = gray_to_bin(rd_gray);

endmodule

// ==== design/rx_block_ring.sv ====
// Receive ring top: write counter, sync-header and payload rings, read mux, page crosser

`timescale 1ns/1ps

module rx_block_ring (
   input  logic                          wr_clk,
   input  logic                          rd_clk,
   input  logic                          reset,
   input  logic                          wrena,
   input  logic                          wrreq,
   input  block_format_pkg::block_t      data_in,
   input  ring_geometry_pkg::dma_addr_t  rd_address,
   output block_format_pkg::dma_word_t   data_out,
   output ring_geometry_pkg::page_cnt_t  wr_page_count
);

   // Write path
   block_format_pkg::block_t     wr_block;
   ring_geometry_pkg::page_t     wr_page;
   ring_geometry_pkg::slot_t     wr_slot;
   logic                         wr_strobe;
   logic                         page_done;

   // Read path
   ring_geometry_pkg::page_t     sync_page;
   logic [2:0]                   sync_word;
   block_format_pkg::dma_word_t  sync_data;
   block_format_pkg::dma_word_t  payload_data;

   block_write_counter write_counter (
      .wr_clk    (wr_clk),
      .reset     (reset),
      .wrena     (wrena),
      .wrreq     (wrreq),
      .data_in   (data_in),
      .wr_block  (wr_block),
      .wr_page   (wr_page),
      .wr_slot   (wr_slot),
      .wr_strobe (wr_strobe),
      .page_done (page_done)
   );

   // Header bits 1:0 of each block
   sync_header_ring sync_ring (
      .wr_clk    (wr_clk),
      .rd_clk    (rd_clk),
      .wr_page   (wr_page),
      .wr_slot   (wr_slot),
      .wr_hdr    (wr_block[block_format_pkg::hdr_width-1:0]),
      .wr_strobe (wr_strobe),
      .rd_page   (sync_page),
      .rd_word   (sync_word),
      .rd_data   (sync_data)
   );

   // Payload bits 65:2, read with the raw DMA address
   data_block_ring data_ring (
      .wr_clk     (wr_clk),
      .rd_clk     (rd_clk),
      .wr_page    (wr_page),
      .wr_slot    (wr_slot),
      .wr_payload (wr_block[block_format_pkg::block_width-1:block_format_pkg::hdr_width]),
      .wr_strobe  (wr_strobe),
      .rd_address (rd_address),
      .rd_data    (payload_data)
   );

   page_read_mux read_mux (
      .rd_clk       (rd_clk),
      .reset        (reset),
      .rd_address   (rd_address),
      .sync_page    (sync_page),
      .sync_word    (sync_word),
      .sync_data    (sync_data),
      .payload_data (payload_data),
      .data_out     (data_out)
   );

   page_count_crosser count_crosser (
      .wr_clk        (wr_clk),
      .rd_clk        (rd_clk),
      .reset         (reset),
      .page_done     (page_done),
      .wr_page_count (wr_page_count)
   );

endmodule

// ==== verif/rx_block_ring_assertions.sv ====
// Bound checks on the receive ring: slot range, page count steps, known read data

`timescale 1ns/1ps

module rx_block_ring_assertions (
   input logic                          wr_clk,
   input logic                          rd_clk,
   input logic                          reset,
   input ring_geometry_pkg::slot_t      wr_slot,
   input ring_geometry_pkg::dma_addr_t  rd_address,
   input block_format_pkg::dma_word_t   data_out,
   input ring_geometry_pkg::page_cnt_t  wr_page_count
);

   // Addressed page already written in full at least once
   // Count of 32 or more means every page has been filled
   logic page_ready;

   // Failed assertions so far
   int fail_count = 0;

   assign page_ready = wr_page_count[5] || (rd_address[12:8] < wr_page_count[4:0]);

   // Slot counter never reaches the empty tail of the page
   slot_range : assert property (@(posedge wr_clk) disable iff (reset)
      wr_slot < ring_geometry_pkg::slot_t'(ring_geometry_pkg::blocks_per_page))
      else begin
         $error("wr_slot left the range of a page");
         fail_count++;
      end

   // Gray transfer moves the count by one step at most
   count_step : assert property (@(posedge rd_clk) disable iff (reset)
      ring_geometry_pkg::page_cnt_t'(wr_page_count - $past(wr_page_count)) <= 1)
      else begin
         $error("wr_page_count jumped by more than one page");
         fail_count++;
      end

   // Known address on a filled page gives known data one cycle later
   read_known : assert property (@(posedge rd_clk) disable iff (reset)
      (!$isunknown(rd_address) && page_ready) |=> !$isunknown(data_out))
      else begin
         $error("data_out holds X after a read of a filled page");
         fail_count++;
      end

endmodule

bind rx_block_ring rx_block_ring_assertions ring_checks (
   .wr_clk        (wr_clk),
   .rd_clk        (rd_clk),
   .reset         (reset),
   .wr_slot       (wr_slot),
   .rd_address    (rd_address),
   .data_out      (data_out),
   .wr_page_count (wr_page_count)
);

// ==== verif/rx_block_ring_tb.sv ====
// Receive ring testbench: clocks, LFSR blocks, reference model, read-back and compare

`timescale 1ns/1ps

module rx_block_ring_tb;

   logic                          wr_clk = 1'b0;
   logic                          rd_clk = 1'b0;
   logic                          reset;
   logic                          wrena;
   logic                          wrreq;
   block_format_pkg::block_t      data_in;
   ring_geometry_pkg::dma_addr_t  rd_address;
   block_format_pkg::dma_word_t   data_out;
   ring_geometry_pkg::page_cnt_t  wr_page_count;

   // Expected ring contents, indexed by ring page and slot
   block_format_pkg::sync_hdr_t ref_hdr [ring_geometry_pkg::page_count]
                                        [ring_geometry_pkg::blocks_per_page];
   block_format_pkg::payload_t  ref_pay [ring_geometry_pkg::page_count]
                                        [ring_geometry_pkg::blocks_per_page];

   logic [31:0]                  lfsr_state;
   int                           ref_page;
   int                           ref_slot;
   int                           pages_written;

   // Read pipeline copy, one rd_clk behind the address
   logic                         rd_valid;
   logic                         rd_valid_q = 1'b0;
   ring_geometry_pkg::dma_addr_t rd_addr_q;

   rx_block_ring UUT (
      .wr_clk        (wr_clk),
      .rd_clk        (rd_clk),
      .reset         (reset),
      .wrena         (wrena),
      .wrreq         (wrreq),
      .data_in       (data_in),
      .rd_address    (rd_address),
      .data_out      (data_out),
      .wr_page_count (wr_page_count)
   );

   // Read side 8 ns, write side 10 ns
   always #4 rd_clk = ~rd_clk;
   always #5 wr_clk = ~wr_clk;

   // ------------------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------------------

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input block_format_pkg::dma_word_t actual,
                              input block_format_pkg::dma_word_t expected);
      if (actual !== expected) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   // Galois form, taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ 32'h8020_0003;
      else
         return state >> 1;
   endfunction

   // One LFSR step per block bit
   task automatic make_block(output block_format_pkg::block_t blk);
      for (int i = 0; i < block_format_pkg::block_width; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         blk[i] = lfsr_state[0];
      end
   endtask

   // Expected DMA word from the placement rules
   function automatic block_format_pkg::dma_word_t expected_word(
      input ring_geometry_pkg::dma_addr_t addr
   );
      int                          page;
      int                          word;
      int                          slot;
      block_format_pkg::dma_word_t result;
      page   = int'(addr[12:8]);
      word   = int'(addr[7:0]);
      result = '0;
      if (word < ring_geometry_pkg::sync_words_per_page) begin
         // 64 headers per word, positions past 495 stay zero
         for (int j = 0; j < 64; j++) begin
            slot = word * 64 + j;
            if (slot < ring_geometry_pkg::blocks_per_page)
               result[2*j +: 2] = ref_hdr[page][slot];
         end
      end else begin
         slot            = 2 * (word - ring_geometry_pkg::sync_words_per_page);
         result[63:0]    = ref_pay[page][slot];
         result[127:64]  = ref_pay[page][slot+1];
      end
      return result;
   endfunction

   // ------------------------------------------------------------------------
   // Write and read tasks
   // ------------------------------------------------------------------------

   // Only blocks with both wrena and wrreq high enter the reference
   task automatic send_block(input logic en, input logic req);
      block_format_pkg::block_t blk;
      make_block(blk);
      @(negedge wr_clk);
      wrena   = en;
      wrreq   = req;
      data_in = blk;
      if (en && req) begin
         ref_hdr[ref_page][ref_slot] = blk[1:0];
         ref_pay[ref_page][ref_slot] = blk[65:2];
         if (ref_slot == ring_geometry_pkg::blocks_per_page - 1) begin
            ref_slot = 0;
            ref_page = (ref_page + 1) % ring_geometry_pkg::page_count;
            pages_written++;
         end else begin
            ref_slot++;
         end
      end
   endtask

   // Full page, optionally mixed with rejected blocks
   task automatic write_page(input bit with_skips);
      for (int i = 0; i < ring_geometry_pkg::blocks_per_page; i++) begin
         if (with_skips && (i % 7 == 3))
            send_block(1'b0, 1'b1);
         if (with_skips && (i % 11 == 5))
            send_block(1'b1, 1'b0);
         send_block(1'b1, 1'b1);
      end
      @(negedge wr_clk);
      wrena = 1'b0;
      wrreq = 1'b0;
   endtask

   task automatic wait_page_count(input int target);
      int cycles;
      cycles = 0;
      while (wr_page_count != ring_geometry_pkg::page_cnt_t'(target)) begin
         @(negedge rd_clk);
         cycles++;
         if (cycles > 20) begin
            $display("Timeout: wr_page_count did not reach %0d after %0d read cycles",
                     target, cycles);
            abort_run();
         end
      end
   endtask

   // Back-to-back reads of every word of one page
   task automatic read_page(input int page);
      for (int w = 0; w < ring_geometry_pkg::words_per_page; w++) begin
         @(negedge rd_clk);
         rd_address = {ring_geometry_pkg::page_t'(page), 8'(w)};
         rd_valid   = 1'b1;
      end
      @(negedge rd_clk);
      rd_valid = 1'b0;
      @(negedge rd_clk);
   endtask

   // ------------------------------------------------------------------------
   // Compare process
   // ------------------------------------------------------------------------

   always @(posedge rd_clk) begin
      rd_valid_q <= rd_valid;
      rd_addr_q  <= rd_address;
   end

   // data_out settled since the rising edge
   always @(negedge rd_clk) begin
      if (rd_valid_q)
         check_value("data_out", data_out, expected_word(rd_addr_q));
   end

   // Bound assertions raise their failure count
   always @(UUT.ring_checks.fail_count) begin
      if (UUT.ring_checks.fail_count != 0) begin
         $display("A bound assertion on the receive ring failed at %0t ns", $time);
         abort_run();
      end
   end

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial begin
      reset         = 1'b1;
      wrena         = 1'b0;
      wrreq         = 1'b0;
      data_in       = '0;
      rd_address    = '0;
      rd_valid      = 1'b0;
      lfsr_state    = 32'h36b8f524;
      ref_page      = 0;
      ref_slot      = 0;
      pages_written = 0;

      repeat (3) @(posedge rd_clk);
      @(negedge rd_clk);
      reset = 1'b0;

      // Idle ring keeps a zero count
      for (int i = 0; i < 40; i++) begin
         @(negedge rd_clk);
         check_value("wr_page_count", wr_page_count, '0);
      end

      // First page, headers then payload pairs
      write_page(1'b0);
      wait_page_count(pages_written);
      read_page(0);

      // Rejected blocks must not show up in page 1
      write_page(1'b1);
      wait_page_count(pages_written);
      read_page(1);

      // Fill to 33 pages, page 0 gets overwritten
      while (pages_written < 33) begin
         write_page(1'b0);
         wait_page_count(pages_written);
      end
      check_value("wr_page_count", wr_page_count, 33);
      read_page(0);
      read_page(1);
      read_page(31);

      $display("TEST OK");
      $finish;
   end

endmodule

// ==== list.f ====
design/ring_geometry_pkg.sv
design/block_format_pkg.sv
design/block_write_counter.sv
design/sync_header_ring.sv
design/data_block_ring.sv
design/page_read_mux.sv
design/page_count_crosser.sv
design/rx_block_ring.sv
verif/rx_block_ring_assertions.sv
verif/rx_block_ring_tb.sv
